// File: vlog.f
verilog/vlsu_isa_pkg.sv
verilog/vlsu_mem_pkg.sv
verilog/vlsu_decode.sv
verilog/vlsu_mem_issue.sv
verilog/vlsu_reorder_buffer.sv
verilog/vlsu_writeback.sv
verilog/vlsu_top.sv
testbench/tb_clk_gen.sv
testbench/tb_mem_model.sv
testbench/tb_vlsu.sv

// File: testbench/tb_vlsu.sv
/* Testbench of the vector load/store unit. Runs loads, stores and an empty
   instruction against the memory model and checks memory, VRF and responses */
`timescale 1ns/1ps

module tb_vlsu;

  localparam int unsigned VELE        = 8;
  localparam int unsigned VRF_WORDS   = vlsu_isa_pkg::NR_VREGS * VELE;
  localparam int unsigned VRF_AW      = $clog2(VRF_WORDS);
  localparam int unsigned PERIOD_NS   = 40;
  localparam int unsigned N_TESTS     = 6;
  localparam int unsigned TEST_CYCLES = 400;

  logic                      clk_i, arst_n_i;
  vlsu_isa_pkg::vlsu_req_t   req_i;
  logic                      req_valid_i, req_ready_o;
  vlsu_isa_pkg::vlsu_rsp_t   rsp_o;
  logic                      rsp_valid_o;
  vlsu_mem_pkg::mem_req_t    mem_req_o, held_req;
  logic                      mem_valid_o, mem_ready_i, held_q;
  vlsu_mem_pkg::mem_result_t mem_result_i;
  logic                      mem_result_valid_i;
  logic [VRF_AW-1:0]         vrf_waddr_o, vrf_raddr_o;
  logic [31:0]               vrf_wdata_o, vrf_rdata_i;
  logic                      vrf_we_o;
  logic [3:0]                vrf_wbe_o;

  int          err_cnt = 0;
  int          chk_cnt = 0;
  int          test_err_base = 0;
  int          rsp_cnt = 0;
  logic [7:0]  exp_mem [1024];
  logic [31:0] exp_vrf [VRF_WORDS];
  logic [3:0]  wbe_log [$];
  logic        last_log [$];

  tb_clk_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(3)) i_clk_gen (
    .clk_o   (clk_i),
    .arst_n_o(arst_n_i)
  );

  vlsu_top #(.NR_OUTSTANDING(4), .VELE(VELE)) i_dut (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .req_i(req_i), .req_valid_i(req_valid_i), .req_ready_o(req_ready_o),
    .rsp_o(rsp_o), .rsp_valid_o(rsp_valid_o),
    .mem_req_o(mem_req_o), .mem_valid_o(mem_valid_o), .mem_ready_i(mem_ready_i),
    .mem_result_i(mem_result_i), .mem_result_valid_i(mem_result_valid_i),
    .vrf_waddr_o(vrf_waddr_o), .vrf_wdata_o(vrf_wdata_o), .vrf_we_o(vrf_we_o),
    .vrf_wbe_o(vrf_wbe_o), .vrf_raddr_o(vrf_raddr_o), .vrf_rdata_i(vrf_rdata_i)
  );

  tb_mem_model #(.VRF_WORDS(VRF_WORDS)) i_mem_model (
    .clk_i(clk_i),
    .mem_req_i(mem_req_o), .mem_valid_i(mem_valid_o), .mem_ready_o(mem_ready_i),
    .mem_result_o(mem_result_i), .mem_result_valid_o(mem_result_valid_i),
    .vrf_waddr_i(vrf_waddr_o), .vrf_wdata_i(vrf_wdata_o), .vrf_we_i(vrf_we_o),
    .vrf_wbe_i(vrf_wbe_o), .vrf_raddr_i(vrf_raddr_o), .vrf_rdata_o(vrf_rdata_i)
  );

  task automatic check(input logic ok, input string msg);
    chk_cnt++;
    assert (ok) else begin
      $display("[FAIL] %0t ns: %s", $time, msg);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////
  // Monitor, sampled mid-cycle
  ////////////////////////////////////////

  initial held_q = 1'b0;

  always @(negedge clk_i) begin
    if (rsp_valid_o) rsp_cnt++;
    if (vrf_we_o) wbe_log.push_back(vrf_wbe_o);
    if (mem_valid_o && mem_ready_i) last_log.push_back(mem_req_o.last);
    if (held_q) begin
      check(mem_valid_o && mem_req_o == held_req, "memory request changed while stalled");
    end
    held_q   = mem_valid_o && !mem_ready_i;
    held_req = mem_req_o;
  end

  ////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////

  // Apply the access to the expected memory and register images
  task automatic predict(input vlsu_isa_pkg::vlsu_req_t req);
    int  eb, a, r;
    logic load, strided;
    eb      = 1 << req.vsew;
    load    = req.op == vlsu_isa_pkg::VLE || req.op == vlsu_isa_pkg::VLSE;
    strided = req.op == vlsu_isa_pkg::VLSE || req.op == vlsu_isa_pkg::VSSE;
    for (int k = 0; k < req.vl; k++) begin
      for (int b = 0; b < eb; b++) begin
        r = k * eb + b;
        a = strided ? int'(req.rs1) + k * int'(req.rs2) + b : int'(req.rs1) + r;
        if (load) exp_vrf[req.vd * VELE + r / 4][8 * (r % 4) +: 8] = exp_mem[a & 1023];
        else exp_mem[a & 1023] = exp_vrf[req.vd * VELE + r / 4][8 * (r % 4) +: 8];
      end
    end
  endtask

  task automatic compare_state();
    for (int a = 0; a < 1024; a++) begin
      check(i_mem_model.mem[a] == exp_mem[a], $sformatf("memory byte 0x%03h is %02h, expected %02h",
            a, i_mem_model.mem[a], exp_mem[a]));
    end
    for (int w = 0; w < VRF_WORDS; w++) begin
      check(i_mem_model.vrf[w] == exp_vrf[w], $sformatf("VRF word %0d is %08h, expected %08h",
            w, i_mem_model.vrf[w], exp_vrf[w]));
    end
  endtask

  // One request per element when strided, one per word otherwise
  task automatic audit_requests(input vlsu_isa_pkg::vlsu_req_t req);
    int n_exp;
    n_exp = (req.op == vlsu_isa_pkg::VLSE || req.op == vlsu_isa_pkg::VSSE) ?
            int'(req.vl) : (int'(req.vl) * (1 << req.vsew) + 3) / 4;
    check(last_log.size() == n_exp, $sformatf("%0d memory requests taken, expected %0d",
          last_log.size(), n_exp));
    foreach (last_log[i]) begin
      check(last_log[i] == (i == n_exp - 1), "last flag on the wrong memory request");
    end
  endtask

  // Issue one instruction and wait for its single response
  task automatic run_insn(input vlsu_isa_pkg::vlsu_req_t req);
    int wait_cyc, rsp_before;
    @(posedge clk_i);
    #2;
    req_i       = req;
    req_valid_i = 1'b1;
    @(negedge clk_i);
    while (!req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b0;
    rsp_before  = rsp_cnt;
    wait_cyc    = 0;
    @(negedge clk_i);
    while (!rsp_valid_o && wait_cyc < TEST_CYCLES) begin
      check(!req_ready_o, "req_ready_o high while an instruction is active");
      @(negedge clk_i);
      wait_cyc++;
    end
    if (!rsp_valid_o) begin
      $display("No response to instruction %0d within %0d cycles", req.id, TEST_CYCLES);
      err_cnt++;
    end else begin
      check(rsp_o.id == req.id && rsp_o.vd == req.vd, "response carries wrong id or vd");
    end
    @(negedge clk_i);
    #1;
    check(rsp_cnt == rsp_before + 1, "instruction did not give exactly one response");
  endtask

  task automatic exec(input vlsu_isa_pkg::vlsu_req_t req);
    for (int a = 0; a < 1024; a++) exp_mem[a] = i_mem_model.mem[a];
    for (int w = 0; w < VRF_WORDS; w++) exp_vrf[w] = i_mem_model.vrf[w];
    predict(req);
    wbe_log.delete();
    last_log.delete();
    run_insn(req);
    compare_state();
    audit_requests(req);
  endtask

  task automatic report_test(input int n, input string name);
    $display("Test %0d (%s): %0d errors", n, name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    req_i       = '0;
    req_valid_i = 1'b0;
    wait (arst_n_i);
    @(negedge clk_i);
    check(!mem_valid_o && !vrf_we_o && !rsp_valid_o && req_ready_o, "outputs not idle after reset");
    report_test(1, "reset state");

    exec('{3'd1, vlsu_isa_pkg::VLE, 5'd2, vlsu_isa_pkg::EW_32, 8'd8, 32'h100, 32'd0});
    check(wbe_log.size() == 8, "unit-stride word load wrote wrong number of words");
    foreach (wbe_log[i]) check(wbe_log[i] == 4'hf, "word load byte enable not full");
    report_test(2, "unit-stride load e32");

    exec('{3'd2, vlsu_isa_pkg::VLE, 5'd3, vlsu_isa_pkg::EW_8, 8'd5, 32'h040, 32'd0});
    check(wbe_log.size() == 2 && wbe_log[1] == 4'b0001, "tail word byte enable wrong");
    report_test(3, "unit-stride load e8");

    exec('{3'd3, vlsu_isa_pkg::VLSE, 5'd4, vlsu_isa_pkg::EW_16, 8'd10, 32'h122, 32'd6});
    report_test(4, "strided load e16");

    exec('{3'd4, vlsu_isa_pkg::VSE, 5'd5, vlsu_isa_pkg::EW_16, 8'd7, 32'h200, 32'd0});
    exec('{3'd5, vlsu_isa_pkg::VSSE, 5'd6, vlsu_isa_pkg::EW_8, 8'd9, 32'h281, 32'd5});
    report_test(5, "stores");

    // Empty vector is answered without any access
    exec('{3'd6, vlsu_isa_pkg::VLE, 5'd7, vlsu_isa_pkg::EW_32, 8'd0, 32'h300, 32'd0});
    check(wbe_log.size() == 0, "empty instruction wrote the VRF");
    report_test(6, "response and vl 0");

    $display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(N_TESTS * TEST_CYCLES * PERIOD_NS);
    $display("Watchdog expired, run did not finish in %0d cycles", N_TESTS * TEST_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: testbench/tb_mem_model.sv
/* Byte memory and register file model for the load/store unit testbench.
   Loads return after random delays, so results come back out of order */
`timescale 1ns/1ps

module tb_mem_model #(
  parameter int unsigned VRF_WORDS = 256,
  localparam int unsigned VRF_AW   = $clog2(VRF_WORDS)
) (
  input  logic                      clk_i,
  input  vlsu_mem_pkg::mem_req_t    mem_req_i,
  input  logic                      mem_valid_i,
  output logic                      mem_ready_o,
  output vlsu_mem_pkg::mem_result_t mem_result_o,
  output logic                      mem_result_valid_o,
  input  logic [VRF_AW-1:0]         vrf_waddr_i,
  input  logic [31:0]               vrf_wdata_i,
  input  logic                      vrf_we_i,
  input  logic [3:0]                vrf_wbe_i,
  input  logic [VRF_AW-1:0]         vrf_raddr_i,
  output logic [31:0]               vrf_rdata_o
);

  logic [7:0]             mem [1024];
  logic [31:0]            vrf [VRF_WORDS];
  integer                 seed = 32'h47fb3d2e;
  vlsu_mem_pkg::mem_req_t req;
  logic                   take, we;
  logic [VRF_AW-1:0]      waddr;
  logic [31:0]            wdata;
  logic [3:0]             wbe;
  logic [9:0]             base;
  int                     sel;
  logic [2:0]             pend_id [$];
  logic [31:0]            pend_data [$];
  int                     pend_wait [$];

  assign vrf_rdata_o = vrf[vrf_raddr_i];

  initial begin
    for (int a = 0; a < 1024; a++) mem[a] = 8'((a * 37) ^ (a >> 8) ^ 8'h5a);
    for (int i = 0; i < VRF_WORDS; i++) vrf[i] = (32'(i) * 32'h9e3779b1) ^ 32'h3c00_00a5;
    mem_ready_o        = 1'b0;
    mem_result_o       = '0;
    mem_result_valid_o = 1'b0;
    forever begin
      // Everything seen here is taken at the coming edge
      @(negedge clk_i);
      take  = mem_valid_i && mem_ready_o;
      req   = mem_req_i;
      we    = vrf_we_i;
      waddr = vrf_waddr_i;
      wdata = vrf_wdata_i;
      wbe   = vrf_wbe_i;
      @(posedge clk_i);
      #2;
      for (int k = 0; k < 4; k++) begin
        if (we && wbe[k]) vrf[waddr][8*k +: 8] = wdata[8*k +: 8];
      end
      base = req.addr[9:0];
      for (int i = 0; i < pend_wait.size(); i++) pend_wait[i]--;
      if (take && req.we) begin
        for (int k = 0; k < 4; k++) begin
          if (req.strb[k]) mem[base + 10'(k)] = req.wdata[8*k +: 8];
        end
      end else if (take) begin
        pend_id.push_back(req.id);
        pend_data.push_back({mem[base + 10'd3], mem[base + 10'd2], mem[base + 10'd1], mem[base]});
        pend_wait.push_back(1 + int'($unsigned($random(seed)) % 6));
      end
      // Oldest result whose delay has run out goes first
      sel = -1;
      for (int i = 0; i < pend_wait.size(); i++) begin
        if (sel < 0 && pend_wait[i] <= 0) sel = i;
      end
      mem_result_valid_o = sel >= 0;
      if (sel >= 0) begin
        mem_result_o.id    = pend_id[sel];
        mem_result_o.rdata = pend_data[sel];
        pend_id.delete(sel);
        pend_data.delete(sel);
        pend_wait.delete(sel);
      end
      mem_ready_o = ($unsigned($random(seed)) % 3) != 0;
    end
  end

endmodule

// File: testbench/tb_clk_gen.sv
/* Testbench clock and asynchronous reset source */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 40,
  parameter int unsigned RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release away from the clock edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    arst_n_o = 1'b1;
  end

endmodule

// File: verilog/vlsu_top.sv
/* Vector load/store unit top level, one memory port and one element word
   per cycle. Connects decode, request issue, reorder buffer and writeback */
`timescale 1ns/1ps

module vlsu_top #(
  parameter  int unsigned NR_OUTSTANDING = 4,
  parameter  int unsigned VELE           = 8,
  localparam int unsigned VRF_AW         = $clog2(vlsu_isa_pkg::NR_VREGS * VELE)
) (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  // Instruction and response
  input  vlsu_isa_pkg::vlsu_req_t            req_i,
  input  logic                               req_valid_i,
  output logic                               req_ready_o,
  output vlsu_isa_pkg::vlsu_rsp_t            rsp_o,
  output logic                               rsp_valid_o,
  // Memory port
  output vlsu_mem_pkg::mem_req_t             mem_req_o,
  output logic                               mem_valid_o,
  input  logic                               mem_ready_i,
  input  vlsu_mem_pkg::mem_result_t          mem_result_i,
  input  logic                               mem_result_valid_i,
  // Register file
  output logic [VRF_AW-1:0]                  vrf_waddr_o,
  output logic [vlsu_isa_pkg::ELEN-1:0]      vrf_wdata_o,
  output logic                               vrf_we_o,
  output logic [vlsu_isa_pkg::ELENB-1:0]     vrf_wbe_o,
  output logic [VRF_AW-1:0]                  vrf_raddr_o,
  input  logic [vlsu_isa_pkg::ELEN-1:0]      vrf_rdata_i
);

  vlsu_isa_pkg::vlsu_cmd_t             cmd;
  logic                                mem_done, vrf_done;
  logic                                rob_alloc, rob_full;
  logic [$clog2(NR_OUTSTANDING)-1:0]   rob_id;
  logic [vlsu_mem_pkg::MEM_DW-1:0]     head_data;
  logic                                head_valid, pop;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  vlsu_decode i_decode (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (req_i),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .cmd_o      (cmd),
    .rsp_o      (rsp_o),
    .rsp_valid_o(rsp_valid_o),
    .mem_done_i (mem_done),
    .vrf_done_i (vrf_done)
  );

  ////////////////////////////////////////
  // Memory side
  ////////////////////////////////////////

  vlsu_mem_issue #(
    .NR_OUTSTANDING(NR_OUTSTANDING),
    .VELE          (VELE)
  ) i_mem_issue (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .cmd_i      (cmd),
    .mem_req_o  (mem_req_o),
    .mem_valid_o(mem_valid_o),
    .mem_ready_i(mem_ready_i),
    .rob_alloc_o(rob_alloc),
    .rob_id_i   (rob_id),
    .rob_full_i (rob_full),
    .vrf_raddr_o(vrf_raddr_o),
    .vrf_rdata_i(vrf_rdata_i),
    .mem_done_o (mem_done)
  );

  vlsu_reorder_buffer #(
    .NR_OUTSTANDING(NR_OUTSTANDING)
  ) i_reorder_buffer (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .alloc_i       (rob_alloc),
    .id_o          (rob_id),
    .full_o        (rob_full),
    .result_i      (mem_result_i),
    .result_valid_i(mem_result_valid_i),
    .head_data_o   (head_data),
    .head_valid_o  (head_valid),
    .pop_i         (pop)
  );

  ////////////////////////////////////////
  // Register file side
  ////////////////////////////////////////

  vlsu_writeback #(
    .VELE(VELE)
  ) i_writeback (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cmd_i       (cmd),
    .head_data_i (head_data),
    .head_valid_i(head_valid),
    .pop_o       (pop),
    .vrf_waddr_o (vrf_waddr_o),
    .vrf_wdata_o (vrf_wdata_o),
    .vrf_we_o    (vrf_we_o),
    .vrf_wbe_o   (vrf_wbe_o),
    .vrf_done_o  (vrf_done)
  );

endmodule

// File: verilog/vlsu_writeback.sv
/* Load writeback: takes words from the reorder buffer head in order, moves
   elements into their register lanes and writes them with byte enables */
`timescale 1ns/1ps

module vlsu_writeback #(
  parameter  int unsigned VELE   = 8,
  localparam int unsigned VRF_AW = $clog2(vlsu_isa_pkg::NR_VREGS * VELE)
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  vlsu_isa_pkg::vlsu_cmd_t             cmd_i,
  input  logic [vlsu_mem_pkg::MEM_DW-1:0]     head_data_i,
  input  logic                                head_valid_i,
  output logic                                pop_o,
  output logic [VRF_AW-1:0]                   vrf_waddr_o,
  output logic [vlsu_isa_pkg::ELEN-1:0]       vrf_wdata_o,
  output logic                                vrf_we_o,
  output logic [vlsu_isa_pkg::ELENB-1:0]      vrf_wbe_o,
  output logic                                vrf_done_o
);

  vlsu_isa_pkg::vlb_t cnt_q, remaining;
  logic [31:0] addr;
  logic        busy, last, store_seen_q;

  assign remaining = cmd_i.vl_bytes - cnt_q;
  assign busy      = cmd_i.active && cmd_i.is_load && (cnt_q < cmd_i.vl_bytes);
  assign last      = remaining <= vlsu_isa_pkg::step_bytes(cmd_i);
  // Memory lane of the element, needed to undo its offset in the word
  assign addr      = vlsu_isa_pkg::elem_addr(cmd_i, cnt_q);

  assign vrf_we_o    = busy && head_valid_i;
  assign pop_o       = vrf_we_o;
  assign vrf_waddr_o = VRF_AW'(cmd_i.vd) * VRF_AW'(VELE) + VRF_AW'(cnt_q >> 2);
  assign vrf_wdata_o = vlsu_isa_pkg::rotl_bytes(head_data_i, cnt_q[1:0] - addr[1:0]);
  assign vrf_wbe_o   = vlsu_isa_pkg::access_mask(cmd_i, remaining, cnt_q[1:0]);

  // Stores never touch the VRF write port, so report done at once
  assign vrf_done_o = (vrf_we_o && last) ||
                      (cmd_i.active && !cmd_i.is_load && !store_seen_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q        <= '0;
      store_seen_q <= 1'b0;
    end else if (!cmd_i.active) begin
      cnt_q        <= '0;
      store_seen_q <= 1'b0;
    end else begin
      if (!cmd_i.is_load) store_seen_q <= 1'b1;
      if (vrf_we_o) cnt_q <= cnt_q + vlsu_isa_pkg::step_bytes(cmd_i);
    end
  end

endmodule

// File: verilog/vlsu_reorder_buffer.sv
/* Reorder buffer for load results: ids are handed out in issue order and
   results, arriving in any order, leave from the head in that same order */
`timescale 1ns/1ps

module vlsu_reorder_buffer #(
  parameter int unsigned NR_OUTSTANDING = 4
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                alloc_i,
  output logic [$clog2(NR_OUTSTANDING)-1:0]   id_o,
  output logic                                full_o,
  input  vlsu_mem_pkg::mem_result_t           result_i,
  input  logic                                result_valid_i,
  output logic [vlsu_mem_pkg::MEM_DW-1:0]     head_data_o,
  output logic                                head_valid_o,
  input  logic                                pop_i
);

  localparam int unsigned PTR_W = $clog2(NR_OUTSTANDING);

  logic [vlsu_mem_pkg::MEM_DW-1:0] data_q [NR_OUTSTANDING];
  logic [NR_OUTSTANDING-1:0]       valid_q;
  logic [PTR_W-1:0]                wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0]                  count_q;
  logic [PTR_W-1:0]                push_idx;

  assign push_idx     = result_i.id[PTR_W-1:0];
  assign id_o         = wr_ptr_q;
  assign full_o       = count_q == (PTR_W+1)'(NR_OUTSTANDING);
  assign head_data_o  = data_q[rd_ptr_q];
  assign head_valid_o = valid_q[rd_ptr_q];

  ////////////////////////////////////////
  // Pointers and slot state
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (alloc_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i) begin
        valid_q[rd_ptr_q] <= 1'b0;
        rd_ptr_q          <= rd_ptr_q + 1'b1;
      end
      // A pushed slot is never the one being popped
      if (result_valid_i) valid_q[push_idx] <= 1'b1;
      case ({alloc_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (result_valid_i) data_q[push_idx] <= result_i.rdata;
  end

endmodule

// File: verilog/vlsu_mem_issue.sv
/* Memory request generator: walks the vector in bytes and issues one request
   per handshake, with load ids from the reorder buffer and store data from the VRF */
`timescale 1ns/1ps

module vlsu_mem_issue #(
  parameter  int unsigned NR_OUTSTANDING = 4,
  parameter  int unsigned VELE           = 8,
  localparam int unsigned VRF_AW         = $clog2(vlsu_isa_pkg::NR_VREGS * VELE)
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  vlsu_isa_pkg::vlsu_cmd_t             cmd_i,
  output vlsu_mem_pkg::mem_req_t              mem_req_o,
  output logic                                mem_valid_o,
  input  logic                                mem_ready_i,
  output logic                                rob_alloc_o,
  input  logic [$clog2(NR_OUTSTANDING)-1:0]   rob_id_i,
  input  logic                                rob_full_i,
  output logic [VRF_AW-1:0]                   vrf_raddr_o,
  input  logic [vlsu_isa_pkg::ELEN-1:0]       vrf_rdata_i,
  output logic                                mem_done_o
);

  vlsu_isa_pkg::vlb_t cnt_q, remaining;
  logic [31:0] addr;
  logic        busy, last, handshake;

  assign remaining = cmd_i.vl_bytes - cnt_q;
  assign busy      = cmd_i.active && (cnt_q < cmd_i.vl_bytes);
  assign last      = remaining <= vlsu_isa_pkg::step_bytes(cmd_i);
  assign addr      = vlsu_isa_pkg::elem_addr(cmd_i, cnt_q);

  // Loads wait for a free reorder buffer slot
  assign mem_valid_o = busy && !(cmd_i.is_load && rob_full_i);
  assign handshake   = mem_valid_o && mem_ready_i;
  assign rob_alloc_o = handshake && cmd_i.is_load;
  assign mem_done_o  = handshake && last;

  always_comb begin
    mem_req_o.id    = cmd_i.is_load ? vlsu_mem_pkg::ID_W'(rob_id_i) : '0;
    mem_req_o.addr  = {addr[31:2], 2'b00};
    mem_req_o.we    = !cmd_i.is_load;
    mem_req_o.strb  = vlsu_isa_pkg::access_mask(cmd_i, remaining, addr[1:0]);
    // Move the element from its register lane to its memory lane
    mem_req_o.wdata = cmd_i.is_load ? '0 :
                      vlsu_isa_pkg::rotl_bytes(vrf_rdata_i, addr[1:0] - cnt_q[1:0]);
    mem_req_o.last  = last;
  end

  assign vrf_raddr_o = VRF_AW'(cmd_i.vd) * VRF_AW'(VELE) + VRF_AW'(cnt_q >> 2);

  // Byte counter, restarts whenever no instruction is active
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (!cmd_i.active) begin
      cnt_q <= '0;
    end else if (handshake) begin
      cnt_q <= cnt_q + vlsu_isa_pkg::step_bytes(cmd_i);
    end
  end

endmodule

// File: verilog/vlsu_decode.sv
/* Instruction front end: holds the active instruction, scales vl to bytes
   and answers once both memory and register file sides are done */
`timescale 1ns/1ps

module vlsu_decode (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  vlsu_isa_pkg::vlsu_req_t req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  output vlsu_isa_pkg::vlsu_cmd_t cmd_o,
  output vlsu_isa_pkg::vlsu_rsp_t rsp_o,
  output logic                    rsp_valid_o,
  input  logic                    mem_done_i,
  input  logic                    vrf_done_i
);

  vlsu_isa_pkg::vlsu_cmd_t cmd_d, cmd_q;
  vlsu_isa_pkg::vlsu_rsp_t rsp_q;
  logic rsp_valid_q;
  logic mem_done_q, vrf_done_q;
  logic accept, finish;

  assign req_ready_o = !cmd_q.active;
  assign accept      = req_valid_i && req_ready_o;
  // Done strobes may arrive in either order, or together
  assign finish      = cmd_q.active && (mem_done_q || mem_done_i) && (vrf_done_q || vrf_done_i);

  always_comb begin
    cmd_d.active     = req_i.vl != 8'd0;
    cmd_d.is_load    = (req_i.op == vlsu_isa_pkg::VLE) || (req_i.op == vlsu_isa_pkg::VLSE);
    cmd_d.is_strided = (req_i.op == vlsu_isa_pkg::VLSE) || (req_i.op == vlsu_isa_pkg::VSSE);
    cmd_d.vsew       = req_i.vsew;
    cmd_d.elem_bytes = 3'd1 << req_i.vsew;
    cmd_d.vl_bytes   = vlsu_isa_pkg::vlb_t'(req_i.vl) << req_i.vsew;
    cmd_d.base       = req_i.rs1;
    cmd_d.stride     = req_i.rs2;
    cmd_d.vd         = req_i.vd;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cmd_q       <= '0;
      rsp_valid_q <= 1'b0;
      mem_done_q  <= 1'b0;
      vrf_done_q  <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;
      if (accept) begin
        cmd_q      <= cmd_d;
        mem_done_q <= 1'b0;
        vrf_done_q <= 1'b0;
        // Empty vector, nothing to move
        if (!cmd_d.active) rsp_valid_q <= 1'b1;
      end else if (finish) begin
        cmd_q.active <= 1'b0;
        rsp_valid_q  <= 1'b1;
      end else begin
        if (mem_done_i) mem_done_q <= 1'b1;
        if (vrf_done_i) vrf_done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q.id <= req_i.id;
      rsp_q.vd <= req_i.vd;
    end
  end

  assign cmd_o       = cmd_q;
  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

endmodule

// File: verilog/vlsu_mem_pkg.sv
/* Memory-side definitions of the load/store unit: data and id widths,
   request and load result records */
package vlsu_mem_pkg;

  localparam int unsigned MEM_DW = 32;
  // Enough for a reorder buffer of up to 8 entries
  localparam int unsigned ID_W   = 3;

  typedef struct packed {
    logic [ID_W-1:0]     id;
    logic [31:0]         addr;
    logic                we;
    logic [MEM_DW/8-1:0] strb;
    logic [MEM_DW-1:0]   wdata;
    logic                last;
  } mem_req_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [MEM_DW-1:0] rdata;
  } mem_result_t;

endpackage

// File: verilog/vlsu_isa_pkg.sv
/* Instruction-side types of the vector load/store unit, with the helpers that
   the issue and writeback stages share for addresses, masks and lane moves */
package vlsu_isa_pkg;

  localparam int unsigned ELEN     = 32;
  localparam int unsigned ELENB    = ELEN / 8;
  localparam int unsigned NR_VREGS = 32;

  typedef enum logic [1:0] {
    VLE  = 2'd0,
    VSE  = 2'd1,
    VLSE = 2'd2,
    VSSE = 2'd3
  } vlsu_op_e;

  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vsew_e;

  typedef logic [2:0]                    insn_id_t;
  typedef logic [$clog2(NR_VREGS)-1:0]   vreg_t;
  // Vector length in bytes, 255 elements of 4 bytes at most
  typedef logic [9:0]                    vlb_t;

  typedef struct packed {
    insn_id_t    id;
    vlsu_op_e    op;
    vreg_t       vd;
    vsew_e       vsew;
    logic [7:0]  vl;
    logic [31:0] rs1;
    logic [31:0] rs2;
  } vlsu_req_t;

  typedef struct packed {
    insn_id_t id;
    vreg_t    vd;
  } vlsu_rsp_t;

  typedef struct packed {
    logic        active;
    logic        is_load;
    logic        is_strided;
    vsew_e       vsew;
    logic [2:0]  elem_bytes;
    vlb_t        vl_bytes;
    logic [31:0] base;
    logic [31:0] stride;
    vreg_t       vd;
  } vlsu_cmd_t;

  ////////////////////////////////////////
  // Shared helpers
  ////////////////////////////////////////

  // Rotate a word left by whole bytes
  function automatic logic [ELEN-1:0] rotl_bytes(logic [ELEN-1:0] w, logic [1:0] n);
    logic [2*ELEN-1:0] dbl;
    dbl = {w, w} << (8 * n);
    return dbl[2*ELEN-1:ELEN];
  endfunction

  // Bytes consumed per access
  function automatic vlb_t step_bytes(vlsu_cmd_t cmd);
    return cmd.is_strided ? vlb_t'(cmd.elem_bytes) : vlb_t'(ELENB);
  endfunction

  // Byte address of the access at register byte offset cnt
  function automatic logic [31:0] elem_addr(vlsu_cmd_t cmd, vlb_t cnt);
    logic [31:0] idx;
    idx = 32'(cnt >> cmd.vsew);
    return cmd.is_strided ? cmd.base + idx * cmd.stride : cmd.base + 32'(cnt);
  endfunction

  // Strided: element mask moved to its lane. Unit-stride: remaining bytes only
  function automatic logic [ELENB-1:0] access_mask(vlsu_cmd_t cmd, vlb_t rem,
                                                  logic [1:0] lane);
    logic [ELENB-1:0] mask;
    if (cmd.is_strided) begin
      case (cmd.vsew)
        EW_8:    mask = 4'b0001;
        EW_16:   mask = 4'b0011;
        default: mask = 4'b1111;
      endcase
      mask = mask << lane;
    end else begin
      for (int k = 0; k < ELENB; k++) begin
        mask[k] = rem > vlb_t'(k);
      end
    end
    return mask;
  endfunction

endpackage
